/* files.f */
sys_pkg.sv
icache.sv
fetch.sv
inst_buffer.sv
dispatch.sv
fetch_top.sv
tb_mem_model.sv
fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@if grep -q "Some tests failed" $(LOG); then \
		echo "FAIL, see $(LOG)"; exit 1; \
	elif grep -q "All tests passed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* fetch_tb.sv */
module fetch_tb;
    import sys_pkg::*;

    localparam int NUM_MEM_TAGS    = 15;
    localparam int ICACHE_LINES    = 32;
    localparam int INST_BUFF_DEPTH = 16;
    localparam int DISPATCH_WIDTH  = 2;
    localparam int SLOT_W          = $clog2(DISPATCH_WIDTH+1);
    localparam int CLOCK_PERIOD    = 10;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_CYCLES      = 20000;
    localparam int MARGIN_CYCLES   = 2000;
    localparam int MIN_DISPATCH    = 1000;
    localparam int STALL_LIMIT     = 1000;
    localparam int WATCHDOG_TIME   = (RESET_CYCLES + NUM_CYCLES + MARGIN_CYCLES) * CLOCK_PERIOD;

    logic                                     clock;
    logic                                     reset;
    addr_t                                    redirect_target;
    br_task_e                                 br_task;
    mem_tag_t                                 mem_tag;
    mem_tag_t                                 mem_data_tag;
    mem_block_t                               mem_data;
    logic [SLOT_W-1:0]                        dispatch_slots;
    logic                                     mem_en;
    addr_t                                    mem_addr;
    dispatch_packet_t [DISPATCH_WIDTH-1:0]    dispatch_out;
    logic [SLOT_W-1:0]                        dispatch_count;
    logic [31:0]                              mem_rand;
    addr_t                                    resp_addr;

    logic [31:0]           rng;
    // expected instruction stream
    addr_t                 exp_pc;
    int                    total_dispatched;
    int                    idle_cycles;
    // inputs the DUT saw at the last edge
    logic                  prev_reset;
    logic                  prev_squash;
    addr_t                 prev_target;
    int                    prev_slots;
    // accepted requests since the last squash
    logic [NUM_MEM_TAGS:1] pend_valid;
    addr_t                 pend_addr [NUM_MEM_TAGS+1];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // hash of the word address
    // about one word in six made a branch
    function automatic inst_t program_word(input addr_t a);
        logic [31:0] h;
        h = (a >> 2) * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        if (h[31:16] % 16'd6 == 16'd0) begin
            return {h[31:7], OPCODE_BRANCH};
        end
        return h;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("FAILED at time %0t: %s", $time, msg));
    endtask

    // one edge of random slots, memory randomness and rare squash
    task automatic drive_cycle(input logic allow_squash);
        @(posedge clock);
        rng = xorshift32(rng);
        dispatch_slots <= SLOT_W'(rng % 32'd3);
        rng = xorshift32(rng);
        mem_rand <= rng;
        rng = xorshift32(rng);
        if (allow_squash && rng[31:25] == 7'd0) begin
            br_task <= SQUASH;
            // small region so the cache sees reuse
            redirect_target <= {22'd0, rng[9:2], 2'b00};
        end else begin
            br_task <= NONE;
        end
    endtask

    // one dispatch lane against the expected stream
    task automatic check_packet(input int i, input int n);
        dispatch_packet_t p;
        inst_t            word;
        p = dispatch_out[i];
        word = program_word(exp_pc);
        if (i >= n) begin
            assert (!p.valid)
                else report_mismatch($sformatf("lane %0d valid beyond count %0d", i, n));
        end else begin
            assert (p.valid && p.pc == exp_pc)
                else report_mismatch($sformatf("lane %0d pc %h, expected %h", i, p.pc, exp_pc));
            assert (p.inst == word && p.npc == exp_pc + 32'd4)
                else report_mismatch($sformatf("pc %h inst %h npc %h, expected %h", p.pc,
                    p.inst, p.npc, word));
            assert (p.opcode == word[6:0] && p.is_branch == (word[6:0] == OPCODE_BRANCH))
                else report_mismatch($sformatf("pc %h predecode wrong", p.pc));
            // group ends right after a branch
            assert (!p.is_branch || i == n - 1)
                else report_mismatch($sformatf("branch at %h not last in group", p.pc));
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    // memory port in the cycle before the accepting edge
    task automatic track_requests();
        if (mem_en) begin
            assert (mem_addr[2:0] == 3'b000)
                else report_mismatch($sformatf("mem_addr %h not block aligned", mem_addr));
        end
        if (mem_en && mem_tag != '0) begin
            for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
                assert (!(pend_valid[t] && pend_addr[t][31:3] == mem_addr[31:3]))
                    else report_mismatch($sformatf("block %h requested twice", mem_addr));
            end
        end
        if (reset || br_task == SQUASH) begin
            pend_valid = '0;
        end else begin
            if (mem_data_tag != '0) begin
                pend_valid[mem_data_tag] = 1'b0;
            end
            if (mem_en && mem_tag != '0) begin
                pend_valid[mem_tag] = 1'b1;
                pend_addr[mem_tag] = mem_addr;
            end
        end
    endtask

    assign mem_data = {program_word(resp_addr + 32'd4), program_word(resp_addr)};

    fetch_top #(
        .NUM_MEM_TAGS    (NUM_MEM_TAGS),
        .ICACHE_LINES    (ICACHE_LINES),
        .INST_BUFF_DEPTH (INST_BUFF_DEPTH),
        .DISPATCH_WIDTH  (DISPATCH_WIDTH)
    ) dut (
        .clock           (clock),
        .reset           (reset),
        .redirect_target (redirect_target),
        .br_task         (br_task),
        .mem_tag         (mem_tag),
        .mem_data_tag    (mem_data_tag),
        .mem_data        (mem_data),
        .dispatch_slots  (dispatch_slots),
        .mem_en          (mem_en),
        .mem_addr        (mem_addr),
        .dispatch_out    (dispatch_out),
        .dispatch_count  (dispatch_count)
    );

    tb_mem_model #(
        .NUM_TAGS (NUM_MEM_TAGS)
    ) mem_model (
        .clock        (clock),
        .reset        (reset),
        .rand_word    (mem_rand),
        .mem_en       (mem_en),
        .mem_addr     (mem_addr),
        .mem_tag      (mem_tag),
        .mem_data_tag (mem_data_tag),
        .resp_addr    (resp_addr)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_TIME);
        stop_run("watchdog expired before the test finished");
    end

    // outputs sampled mid-cycle at the falling edge
    always @(negedge clock) begin
        int n;
        n = int'(dispatch_count);
        if (prev_reset || prev_squash) begin
            assert (n == 0 && !mem_en)
                else stop_run("dispatch or memory request in the cycle after reset or squash");
            exp_pc = prev_reset ? '0 : prev_target;
            idle_cycles = 0;
        end else begin
            assert (n <= prev_slots && n <= DISPATCH_WIDTH)
                else report_mismatch($sformatf("dispatch_count %0d with %0d slots", n,
                    prev_slots));
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                check_packet(i, n);
            end
            total_dispatched = total_dispatched + n;
            idle_cycles = (n == 0) ? idle_cycles + 1 : 0;
            assert (idle_cycles < STALL_LIMIT)
                else stop_run("no instruction dispatched for too long, the flow has stalled");
        end
        track_requests();
        prev_reset  = reset;
        prev_squash = br_task == SQUASH;
        prev_target = redirect_target;
        prev_slots  = int'(dispatch_slots);
    end

    initial begin
        rng              = 32'h9060_9174;
        reset            = 1'b1;
        br_task          = NONE;
        redirect_target  = '0;
        dispatch_slots   = '0;
        mem_rand         = '0;
        exp_pc           = '0;
        total_dispatched = 0;
        idle_cycles      = 0;
        prev_reset       = 1'b1;
        prev_squash      = 1'b0;
        prev_target      = '0;
        prev_slots       = 0;
        pend_valid       = '0;
        repeat (RESET_CYCLES) drive_cycle(1'b0);
        reset <= 1'b0;
        repeat (NUM_CYCLES) drive_cycle(1'b1);
        if (total_dispatched >= MIN_DISPATCH) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_run($sformatf("only %0d instructions dispatched, at least %0d needed",
                total_dispatched, MIN_DISPATCH));
        end
    end

endmodule

/* tb_mem_model.sv */
module tb_mem_model #(
    parameter int NUM_TAGS = 15
) (
    input  logic              clock,
    input  logic              reset,
    input  logic [31:0]       rand_word,
    input  logic              mem_en,
    input  sys_pkg::addr_t    mem_addr,
    output sys_pkg::mem_tag_t mem_tag,
    output sys_pkg::mem_tag_t mem_data_tag,
    output sys_pkg::addr_t    resp_addr
);
    import sys_pkg::*;

    // per-tag request state, due is the first cycle it may come back in
    logic [NUM_TAGS:1] busy;
    addr_t             addr [NUM_TAGS+1];
    int                due  [NUM_TAGS+1];
    int                now;

    initial begin
        mem_tag      = '0;
        mem_data_tag = '0;
        resp_addr    = '0;
        busy         = '0;
        now          = 0;
    end

    always @(posedge clock) begin
        int pick;
        int offer;
        if (reset) begin
            busy = '0;
            now  = 0;
            mem_tag      <= '0;
            mem_data_tag <= '0;
            resp_addr    <= '0;
        end else begin
            now = now + 1;
            // the response on the bus this cycle is done
            if (mem_data_tag != '0) begin
                busy[mem_data_tag] = 1'b0;
            end
            if (mem_en && mem_tag != '0) begin
                busy[mem_tag] = 1'b1;
                addr[mem_tag] = mem_addr;
                // latency 1 to 20
                due[mem_tag] = now + int'(rand_word[15:8] % 8'd20);
            end
            // earliest due among the ready ones, order across tags is free
            pick = 0;
            for (int t = 1; t <= NUM_TAGS; t++) begin
                if (busy[t] && due[t] <= now && (pick == 0 || due[t] < due[pick])) begin
                    pick = t;
                end
            end
            // lowest free tag, or a refusal one time in eight
            offer = 0;
            for (int t = NUM_TAGS; t >= 1; t--) begin
                if (!busy[t]) begin
                    offer = t;
                end
            end
            if (rand_word[2:0] == 3'b000) begin
                offer = 0;
            end
            mem_tag      <= mem_tag_t'(offer);
            mem_data_tag <= mem_tag_t'(pick);
            resp_addr    <= (pick != 0) ? addr[pick] : '0;
        end
    end

endmodule

/* fetch_top.sv */
module fetch_top #(
    parameter int NUM_MEM_TAGS    = 15,
    parameter int ICACHE_LINES    = 32,
    parameter int INST_BUFF_DEPTH = 16,
    parameter int DISPATCH_WIDTH  = 2
) (
    input  logic                                           clock,
    input  logic                                           reset,
    input  sys_pkg::addr_t                                 redirect_target,
    input  sys_pkg::br_task_e                              br_task,
    input  sys_pkg::mem_tag_t                              mem_tag,
    input  sys_pkg::mem_tag_t                              mem_data_tag,
    input  sys_pkg::mem_block_t                            mem_data,
    input  logic [$clog2(DISPATCH_WIDTH+1)-1:0]            dispatch_slots,
    output logic                                           mem_en,
    output sys_pkg::addr_t                                 mem_addr,
    output sys_pkg::dispatch_packet_t [DISPATCH_WIDTH-1:0] dispatch_out,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0]            dispatch_count
);
    import sys_pkg::*;

    logic                                    flush;
    inst_packet_t [FETCH_WIDTH-1:0]          fetch_insts;
    fetch_cnt_t                              fetch_count;
    logic [$clog2(INST_BUFF_DEPTH+1)-1:0]    ibuff_open;
    inst_packet_t [DISPATCH_WIDTH-1:0]       head_insts;
    logic [$clog2(DISPATCH_WIDTH+1)-1:0]     head_count;
    logic [$clog2(DISPATCH_WIDTH+1)-1:0]     pop_count;

    // squash empties buffer and dispatch, fetch decodes br_task itself
    assign flush = br_task == SQUASH;

    fetch #(
        .NUM_MEM_TAGS    (NUM_MEM_TAGS),
        .ICACHE_LINES    (ICACHE_LINES),
        .INST_BUFF_DEPTH (INST_BUFF_DEPTH)
    ) fetch_0 (
        .clock           (clock),
        .reset           (reset),
        .redirect_target (redirect_target),
        .br_task         (br_task),
        .ibuff_open      (ibuff_open),
        .mem_tag         (mem_tag),
        .mem_data_tag    (mem_data_tag),
        .mem_data        (mem_data),
        .mem_en          (mem_en),
        .mem_addr        (mem_addr),
        .fetch_insts     (fetch_insts),
        .fetch_count     (fetch_count)
    );

    inst_buffer #(
        .INST_BUFF_DEPTH (INST_BUFF_DEPTH),
        .DISPATCH_WIDTH  (DISPATCH_WIDTH)
    ) inst_buffer_0 (
        .clock      (clock),
        .reset      (reset),
        .flush      (flush),
        .push_insts (fetch_insts),
        .push_count (fetch_count),
        .pop_count  (pop_count),
        .head_insts (head_insts),
        .head_count (head_count),
        .open_count (ibuff_open)
    );

    dispatch #(
        .DISPATCH_WIDTH (DISPATCH_WIDTH)
    ) dispatch_0 (
        .clock          (clock),
        .reset          (reset),
        .flush          (flush),
        .head_insts     (head_insts),
        .head_count     (head_count),
        .dispatch_slots (dispatch_slots),
        .pop_count      (pop_count),
        .dispatch_out   (dispatch_out),
        .dispatch_count (dispatch_count)
    );

endmodule

/* dispatch.sv */
module dispatch #(
    parameter int DISPATCH_WIDTH = 2
) (
    input  logic                                         clock,
    input  logic                                         reset,
    input  logic                                         flush,
    input  sys_pkg::inst_packet_t [DISPATCH_WIDTH-1:0]   head_insts,
    input  logic [$clog2(DISPATCH_WIDTH+1)-1:0]          head_count,
    input  logic [$clog2(DISPATCH_WIDTH+1)-1:0]          dispatch_slots,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0]          pop_count,
    output sys_pkg::dispatch_packet_t [DISPATCH_WIDTH-1:0] dispatch_out,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0]          dispatch_count
);
    import sys_pkg::*;

    localparam int CNT_W = $clog2(DISPATCH_WIDTH+1);

    logic [CNT_W-1:0]                     limit;
    logic                                 cut;
    dispatch_packet_t [DISPATCH_WIDTH-1:0] next_out;

    always_comb begin
        // smallest of buffered, back-end slots and width
        limit = (head_count < dispatch_slots) ? head_count : dispatch_slots;
        if (int'(limit) > DISPATCH_WIDTH) begin
            limit = CNT_W'(DISPATCH_WIDTH);
        end
        pop_count = '0;
        cut = 1'b0;
        next_out = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (i < limit && !cut) begin
                next_out[i].valid = 1'b1;
                next_out[i].inst = head_insts[i].inst;
                next_out[i].pc = head_insts[i].pc;
                next_out[i].npc = head_insts[i].npc;
                // predecode
                next_out[i].opcode = head_insts[i].inst[6:0];
                next_out[i].is_branch = head_insts[i].inst[6:0] == OPCODE_BRANCH;
                // group ends after a branch
                cut = next_out[i].is_branch;
                pop_count = pop_count + 1'b1;
            end
        end
    end

    // pops at this same edge
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            dispatch_out   <= '0;
            dispatch_count <= '0;
        end else begin
            dispatch_out   <= next_out;
            dispatch_count <= pop_count;
        end
    end

endmodule

/* inst_buffer.sv */
module inst_buffer #(
    parameter int INST_BUFF_DEPTH = 16,
    parameter int DISPATCH_WIDTH  = 2
) (
    input  logic                                             clock,
    input  logic                                             reset,
    input  logic                                             flush,
    input  sys_pkg::inst_packet_t [sys_pkg::FETCH_WIDTH-1:0] push_insts,
    input  sys_pkg::fetch_cnt_t                              push_count,
    input  logic [$clog2(DISPATCH_WIDTH+1)-1:0]              pop_count,
    output sys_pkg::inst_packet_t [DISPATCH_WIDTH-1:0]       head_insts,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0]              head_count,
    output logic [$clog2(INST_BUFF_DEPTH+1)-1:0]             open_count
);
    import sys_pkg::*;

    localparam int PTR_W = $clog2(INST_BUFF_DEPTH);
    localparam int CNT_W = $clog2(INST_BUFF_DEPTH+1);
    localparam int HC_W  = $clog2(DISPATCH_WIDTH+1);

    typedef logic [PTR_W-1:0] ptr_t;

    inst_packet_t     entries [INST_BUFF_DEPTH];
    ptr_t             head;
    ptr_t             tail;
    logic [CNT_W-1:0] count;

    // pointer step with wrap, depth need not be a power of two
    function automatic ptr_t advance(ptr_t p, int k);
        int sum;
        sum = int'(p) + k;
        if (sum >= INST_BUFF_DEPTH) begin
            sum = sum - INST_BUFF_DEPTH;
        end
        return ptr_t'(sum);
    endfunction

    assign open_count = CNT_W'(INST_BUFF_DEPTH) - count;

    // oldest entries, empty slots read as invalid
    always_comb begin
        if (int'(count) >= DISPATCH_WIDTH) begin
            head_count = HC_W'(DISPATCH_WIDTH);
        end else begin
            head_count = HC_W'(count);
        end
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            head_insts[i] = (i < count) ? entries[advance(head, i)] : '0;
        end
    end

    // in-order multi-push at the tail
    always_ff @(posedge clock) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (i < push_count) begin
                entries[advance(tail, i)] <= push_insts[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= advance(head, int'(pop_count));
            tail  <= advance(tail, int'(push_count));
            count <= count + CNT_W'(push_count) - CNT_W'(pop_count);
        end
    end

    // fetch must respect the reported free space
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        int'(push_count) <= int'(open_count))
        else $error("push of %0d with %0d free", push_count, open_count);

    // dispatch pops only what is there
    a_no_underflow: assert property (@(posedge clock) disable iff (reset)
        int'(pop_count) <= int'(count))
        else $error("pop of %0d with %0d held", pop_count, count);

endmodule

/* fetch.sv */
module fetch #(
    parameter int NUM_MEM_TAGS    = 15,
    parameter int ICACHE_LINES    = 32,
    parameter int INST_BUFF_DEPTH = 16
) (
    input  logic                                             clock,
    input  logic                                             reset,
    input  sys_pkg::addr_t                                   redirect_target,
    input  sys_pkg::br_task_e                                br_task,
    input  logic [$clog2(INST_BUFF_DEPTH+1)-1:0]             ibuff_open,
    input  sys_pkg::mem_tag_t                                mem_tag,
    input  sys_pkg::mem_tag_t                                mem_data_tag,
    input  sys_pkg::mem_block_t                              mem_data,
    output logic                                             mem_en,
    output sys_pkg::addr_t                                   mem_addr,
    output sys_pkg::inst_packet_t [sys_pkg::FETCH_WIDTH-1:0] fetch_insts,
    output sys_pkg::fetch_cnt_t                              fetch_count
);
    import sys_pkg::*;

    localparam int OPEN_W = $clog2(INST_BUFF_DEPTH+1);

    logic                          flush;
    addr_t                         pc;
    logic                          live;
    addr_t [NUM_MEM_TAGS:1]        mshr_addr;
    logic  [NUM_MEM_TAGS:1]        mshr_valid;
    logic                          mem_done;
    logic                          mem_accept;
    addr_t                         fill_addr;
    mem_block_t [1:0]              cache_data;
    logic       [1:0]              cache_valid;
    logic       [1:0]              cache_alloc;
    addr_t      [1:0]              blk_addr;
    logic       [1:0]              blk_need;
    logic [OPEN_W-1:0]             room;
    fetch_cnt_t                    avail;
    fetch_cnt_t                    take;
    fetch_cnt_t                    word;
    inst_packet_t [FETCH_WIDTH-1:0] next_insts;

    assign flush = br_task == SQUASH;

    // response only counts if its tag still has a live MSHR
    assign mem_done = mem_data_tag != '0 && int'(mem_data_tag) <= NUM_MEM_TAGS
        && mshr_valid[mem_data_tag];
    assign fill_addr = mem_done ? mshr_addr[mem_data_tag] : '0;
    // memory refuses with tag zero
    assign mem_accept = mem_en && mem_tag != '0;

    // miss selection over the two blocks from the PC
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            blk_addr[i] = {pc[31:3], 3'b000} + (addr_t'(i) << 3);
            blk_need[i] = !cache_valid[i] && !cache_alloc[i];
            for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
                if (mshr_valid[t] && mshr_addr[t][31:3] == blk_addr[i][31:3]) begin
                    blk_need[i] = 1'b0;
                end
            end
        end
        // quiet for one cycle after reset or squash
        mem_en = live && !(&mshr_valid) && |blk_need;
        mem_addr = blk_need[0] ? blk_addr[0] : blk_addr[1];
    end

    // bundle from leading valid blocks
    always_comb begin
        // free space net of the bundle still staged
        if (ibuff_open > OPEN_W'(fetch_count)) begin
            room = ibuff_open - OPEN_W'(fetch_count);
        end else begin
            room = '0;
        end
        avail = '0;
        if (cache_valid[0]) begin
            avail = pc[2] ? 3'd1 : 3'd2;
            if (cache_valid[1]) begin
                avail = avail + 3'd2;
            end
        end
        take = (int'(room) < int'(avail)) ? fetch_cnt_t'(room) : avail;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            // word slot across the two blocks
            word = {2'b00, pc[2]} + fetch_cnt_t'(i);
            next_insts[i] = '0;
            if (i < take) begin
                next_insts[i].valid = 1'b1;
                next_insts[i].inst = cache_data[word[1]][32*word[0] +: 32];
                next_insts[i].pc = pc + addr_t'(4 * i);
                next_insts[i].npc = pc + addr_t'(4 * i + 4);
                // not-taken everywhere
                next_insts[i].pred_taken = 1'b0;
            end
        end
    end

    icache #(
        .ICACHE_LINES (ICACHE_LINES)
    ) icache_0 (
        .clock      (clock),
        .reset      (reset),
        .flush      (flush),
        .read_addr  (pc),
        .alloc_en   (mem_accept),
        .alloc_addr (mem_addr),
        .write_en   (mem_done),
        .write_addr (fill_addr),
        .write_data (mem_data),
        .read_data  (cache_data),
        .read_valid (cache_valid),
        .read_alloc (cache_alloc)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (flush) begin
            pc <= redirect_target;
        end else begin
            pc <= pc + (addr_t'(take) << 2);
        end
    end

    // block address per tag
    always_ff @(posedge clock) begin
        if (mem_accept) begin
            mshr_addr[mem_tag] <= mem_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            live        <= 1'b0;
            mshr_valid  <= '0;
            fetch_insts <= '0;
            fetch_count <= '0;
        end else begin
            live        <= 1'b1;
            fetch_insts <= next_insts;
            fetch_count <= take;
            // free first, a reissued tag wins
            if (mem_done) begin
                mshr_valid[mem_data_tag] <= 1'b0;
            end
            if (mem_accept) begin
                mshr_valid[mem_tag] <= 1'b1;
            end
        end
    end

    // one outstanding miss per block
    for (genvar i = 1; i <= NUM_MEM_TAGS; i++) begin : g_mshr_a
        for (genvar j = i + 1; j <= NUM_MEM_TAGS; j++) begin : g_mshr_b
            a_mshr_unique: assert property (@(posedge clock) disable iff (reset)
                !(mshr_valid[i] && mshr_valid[j]
                  && mshr_addr[i][31:3] == mshr_addr[j][31:3]))
                else $error("MSHR %0d and %0d hold the same block", i, j);
        end
    end

endmodule

/* icache.sv */
module icache #(
    parameter int ICACHE_LINES = 32
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       flush,
    input  sys_pkg::addr_t             read_addr,
    input  logic                       alloc_en,
    input  sys_pkg::addr_t             alloc_addr,
    input  logic                       write_en,
    input  sys_pkg::addr_t             write_addr,
    input  sys_pkg::mem_block_t        write_data,
    output sys_pkg::mem_block_t [1:0]  read_data,
    output logic                [1:0]  read_valid,
    output logic                [1:0]  read_alloc
);
    import sys_pkg::*;

    // block offset is 3 bits, index above it, tag takes the rest
    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = 29 - IDX_W;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    mem_block_t              data [ICACHE_LINES];
    tag_t                    tags [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] valid;
    logic [ICACHE_LINES-1:0] alloc;

    addr_t [1:0] rd_block;
    idx_t        widx;
    idx_t        aidx;

    function automatic idx_t line_idx(addr_t a);
        return a[3 +: IDX_W];
    endfunction

    function automatic tag_t line_tag(addr_t a);
        return a[31 -: TAG_W];
    endfunction

    assign widx = line_idx(write_addr);
    assign aidx = line_idx(alloc_addr);

    // block at read address and the one after it
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd_block[i] = {read_addr[31:3], 3'b000} + (addr_t'(i) << 3);
            read_data[i] = data[line_idx(rd_block[i])];
            // flags only count when the stored tag matches
            read_valid[i] = valid[line_idx(rd_block[i])]
                && tags[line_idx(rd_block[i])] == line_tag(rd_block[i]);
            read_alloc[i] = alloc[line_idx(rd_block[i])]
                && tags[line_idx(rd_block[i])] == line_tag(rd_block[i]);
        end
    end

    // tag claimed at allocation, data on fill
    always_ff @(posedge clock) begin
        if (alloc_en) begin
            tags[aidx] <= line_tag(alloc_addr);
        end
        if (write_en) begin
            data[widx] <= write_data;
            tags[widx] <= line_tag(write_addr);
        end
    end

    // line state, pending on alloc and valid on fill
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            valid <= '0;
            alloc <= '0;
        end else begin
            if (alloc_en) begin
                valid[aidx] <= 1'b0;
                alloc[aidx] <= 1'b1;
            end
            if (write_en) begin
                valid[widx] <= 1'b1;
                alloc[widx] <= 1'b0;
            end
        end
    end

    // a fill must land on the line its miss allocated
    a_fill_allocated: assert property (@(posedge clock) disable iff (reset || flush)
        write_en |-> alloc[widx] && tags[widx] == line_tag(write_addr))
        else $error("icache fill to unallocated line %h", write_addr);

endmodule

/* sys_pkg.sv */
package sys_pkg;

    // byte address and raw instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // memory transaction tag, zero is none or refused
    typedef logic [3:0] mem_tag_t;

    // one memory block, two instruction words, low word at low address
    typedef logic [63:0] mem_block_t;

    // low seven bits of an instruction
    typedef logic [6:0] opcode_t;

    // instructions per fetch bundle, 0 to 4
    typedef logic [2:0] fetch_cnt_t;

    // fetch bundle width
    localparam int FETCH_WIDTH = 4;

    // opcode that predecode treats as a branch
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;

    // back-end branch resolution
    typedef enum logic {
        NONE   = 1'b0,
        SQUASH = 1'b1
    } br_task_e;

    // fetch to buffer entry
    typedef struct packed {
        logic  valid;
        inst_t inst;
        addr_t pc;
        addr_t npc;
        logic  pred_taken;
    } inst_packet_t;

    // predecoded dispatch entry
    typedef struct packed {
        logic    valid;
        inst_t   inst;
        addr_t   pc;
        addr_t   npc;
        logic    is_branch;
        opcode_t opcode;
    } dispatch_packet_t;

endpackage
